//--- src/mul_pkg.sv
// shared types for the two-lane multiply unit
// all products are unsigned and keep only the low 64 bits
// any opb select code other than the immediate picks register B

package mul_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int WORD_W = 64;               // operand and product width
  localparam int LANES  = 2;                // issue lanes from the RS

  typedef logic [WORD_W-1:0] word_t;        // data word
  typedef logic [31:0]       inst_t;        // instruction word
  typedef logic [4:0]        ar_idx_t;      // architectural reg index
  typedef logic [6:0]        pr_idx_t;      // physical reg index

  // operand B source from the decoder
  typedef enum logic [1:0] {
    OPB_IS_REGB    = 2'h0,
    OPB_IS_ALU_IMM = 2'h1
  } opb_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    ar_idx_t dest_ar_idx;                   // arch dest, 5 bits
    pr_idx_t dest_pr_idx;                   // phys dest, 7 bits
  } dest_tag_t;

  // one instruction from the reservation station, 175 bits
  typedef struct packed {
    logic      valid;                       // single-cycle issue strobe
    inst_t     ir;
    word_t     pra;                         // register A value
    word_t     prb;                         // register B value
    opb_sel_e  opb_select;
    dest_tag_t dest;
  } issue_t;

  // state handed between multiplier stages, 205 bits
  typedef struct packed {
    logic      valid;
    dest_tag_t dest;                        // tags ride with the data
    word_t     product;                     // running sum
    word_t     mplier;                      // remaining multiplier digits
    word_t     mcand;                       // shifted multiplicand
  } stage_t;

  // completion bus entry, 77 bits
  typedef struct packed {
    logic      complete;                    // also the prf write enable
    dest_tag_t dest;
    word_t     result;
  } cdb_t;

endpackage

//--- src/mult_stage.sv
// one partial-product stage of the pipelined multiplier
// handles 64/NUM_STAGES multiplier bits per stage, NUM_STAGES must divide 64
// output product is a combinational add of two registers

`timescale 1ns/100ps

module mult_stage
  import mul_pkg::*;
#(
  parameter int NUM_STAGES = 4
) (
  input  logic   clock,
  input  logic   reset,
  input  stage_t stage_in,
  output stage_t stage_out
);

  localparam int DIGIT_W = WORD_W / NUM_STAGES;  // bits consumed per stage

  word_t     partial_product;               // digit times mcand, this cycle
  word_t     prod_q;                        // incoming running sum
  word_t     partial_q;                     // registered partial product
  word_t     mplier_q;
  word_t     mcand_q;
  logic      valid_q;
  dest_tag_t dest_q;

  // narrow multiply, truncated to the low word
  assign partial_product = word_t'(stage_in.mplier[DIGIT_W-1:0]) * stage_in.mcand;

  // payload registers
  always_ff @(posedge clock)
  begin
    prod_q    <= stage_in.product;
    partial_q <= partial_product;
    mplier_q  <= stage_in.mplier >> DIGIT_W;   // drop the used digit
    mcand_q   <= stage_in.mcand << DIGIT_W;    // align to next digit weight
    dest_q    <= stage_in.dest;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      valid_q <= 1'b0;                      // flush in-flight op
    else
      valid_q <= stage_in.valid;
  end

  // accumulate after the register, keeps the multiply and add in separate cycles
  always_comb
  begin
    stage_out.valid   = valid_q;
    stage_out.dest    = dest_q;
    stage_out.product = prod_q + partial_q;
    stage_out.mplier  = mplier_q;
    stage_out.mcand   = mcand_q;
  end

endmodule

//--- src/mult_pipe.sv
// multiplier chain for one lane, NUM_STAGES cycles of latency
// pipe_in product must be zero, the chain only accumulates
// supported depths are 2, 4 and 8

`timescale 1ns/100ps

module mult_pipe
  import mul_pkg::*;
#(
  parameter int NUM_STAGES = 4
) (
  input  logic   clock,
  input  logic   reset,
  input  stage_t pipe_in,
  output stage_t pipe_out
);

  ////////////////////////////////////////////////////////////////////////////
  // stage links
  ////////////////////////////////////////////////////////////////////////////

  // link[0] is the chain input, link[NUM_STAGES] the finished product
  stage_t link [NUM_STAGES+1];

  assign link[0] = pipe_in;

  ////////////////////////////////////////////////////////////////////////////
  // stage chain
  ////////////////////////////////////////////////////////////////////////////

  // stage i multiplies digit i of the original multiplier,
  // since every earlier stage has already shifted its digit out
  for (genvar i = 0; i < NUM_STAGES; i++)
  begin : g_stage
    mult_stage #(
      .NUM_STAGES (NUM_STAGES)
    ) u_stage (
      .clock     (clock),
      .reset     (reset),
      .stage_in  (link[i]),
      .stage_out (link[i+1])
    );
  end

  // after the last stage mplier is all zero and mcand has shifted out,
  // only valid, dest and product carry meaning here
  assign pipe_out = link[NUM_STAGES];

endmodule

//--- src/mul_operand_sel.sv
// issue register and operand-B mux for one lane
// operand A is always register A
// immediate is IR[20:13], zero extended

`timescale 1ns/100ps

module mul_operand_sel
  import mul_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  issue_t issue,
  output stage_t stage_out
);

  localparam int IMM_LSB = 13;              // alu literal field, low bit
  localparam int IMM_MSB = 20;              // alu literal field, high bit

  issue_t issue_q;                          // registered issue
  word_t  alu_imm;
  word_t  opb_mux;

  ////////////////////////////////////////////////////////////////////////////
  // issue register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      issue_q.valid <= 1'b0;
    else
      issue_q.valid <= issue.valid;
  end

  always_ff @(posedge clock)
  begin
    issue_q.ir         <= issue.ir;
    issue_q.pra        <= issue.pra;
    issue_q.prb        <= issue.prb;
    issue_q.opb_select <= issue.opb_select;
    issue_q.dest       <= issue.dest;
  end

  // 8-bit literal, zero extended to a full word
  assign alu_imm = word_t'(issue_q.ir[IMM_MSB:IMM_LSB]);

  always_comb
  begin
    case (issue_q.opb_select)
      OPB_IS_ALU_IMM: opb_mux = alu_imm;
      default:        opb_mux = issue_q.prb;  // regb and unused codes
    endcase
  end

  // first stage word, product starts at zero
  always_comb
  begin
    stage_out.valid   = issue_q.valid;
    stage_out.dest    = issue_q.dest;
    stage_out.product = '0;
    stage_out.mplier  = opb_mux;
    stage_out.mcand   = issue_q.pra;
  end

endmodule

//--- src/alu_mul.sv
// two-lane pipelined multiply unit, latency 1 + NUM_STAGES cycles
// no back-pressure, the completion bus takes a result every cycle
// lanes are independent and keep issue order

`timescale 1ns/100ps

module alu_mul
  import mul_pkg::*;
#(
  parameter int NUM_STAGES = 4              // must divide 64
) (
  input  logic   clock,
  input  logic   reset,
  input  issue_t issue [LANES],
  output cdb_t   cdb   [LANES]
);

  ////////////////////////////////////////////////////////////////////////////
  // lanes
  ////////////////////////////////////////////////////////////////////////////
  for (genvar lane = 0; lane < LANES; lane++)
  begin : g_lane
    stage_t sel_out;                        // operand selector to chain
    stage_t pipe_out;                       // finished product

    mul_operand_sel u_sel (
      .clock     (clock),
      .reset     (reset),
      .issue     (issue[lane]),
      .stage_out (sel_out)
    );

    mult_pipe #(
      .NUM_STAGES (NUM_STAGES)
    ) u_pipe (
      .clock    (clock),
      .reset    (reset),
      .pipe_in  (sel_out),
      .pipe_out (pipe_out)
    );

    // broadcast with the tags that travelled alongside
    assign cdb[lane].complete = pipe_out.valid;
    assign cdb[lane].dest     = pipe_out.dest;
    assign cdb[lane].result   = pipe_out.product;
  end

endmodule

//--- tb/tb_alu_mul.sv
// directed testbench for the two-lane multiply unit, NUM_STAGES fixed at 4
// a scoreboard per lane checks data, tags and latency of every completion
// the scoreboard is flushed whenever reset is sampled high

`timescale 1ns/100ps

module tb_alu_mul
  import mul_pkg::*;
();

  localparam int NUM_STAGES = 4;
  localparam int LATENCY    = 1 + NUM_STAGES;   // issue edge to completion edge

  // issues per test, the bubble count is the expected half of its slots
  localparam int REG_ISSUES    = 2 * 8;
  localparam int IMM_ISSUES    = 2 * 8;
  localparam int STREAM_ISSUES = 2 * 40;
  localparam int BUBBLE_ISSUES = 40;
  localparam int FLUSH_ISSUES  = 2 * 3 + 1;
  localparam int TIMEOUT_CYCLES = REG_ISSUES + IMM_ISSUES + STREAM_ISSUES
                                + BUBBLE_ISSUES + FLUSH_ISSUES + 64;

  // one expected completion
  typedef struct packed {
    word_t       result;
    dest_tag_t   dest;
    logic [31:0] cycle;                     // cycle the DUT sampled the issue
  } exp_t;

  logic   clock;
  logic   reset;
  issue_t issue [LANES];
  cdb_t   cdb   [LANES];

  exp_t exp_q [LANES][$];                   // in-flight issues per lane
  int   cycle_count     = 0;
  int   seen_count      = 0;                // every complete seen on the bus
  int   issued_count    = 0;
  int   value_errors    = 0;
  int   protocol_errors = 0;

  alu_mul #(
    .NUM_STAGES (NUM_STAGES)
  ) DUT (
    .clock (clock),
    .reset (reset),
    .issue (issue),
    .cdb   (cdb)
  );

  always #4 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // reference model and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // low 64 bits of operand A times the selected operand B
  function automatic word_t model_result(input issue_t item);
    word_t opb;
    if (item.opb_select == OPB_IS_ALU_IMM)
      opb = {56'b0, item.ir[20:13]};        // zero-extended literal
    else
      opb = item.prb;
    return item.pra * opb;
  endfunction

  function automatic word_t rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic dest_tag_t rand_tag();
    logic [11:0] bits;
    bits = 12'($urandom);
    return bits;
  endfunction

  function automatic issue_t make_issue(input word_t pra, input word_t prb,
                                        input opb_sel_e sel, input inst_t ir,
                                        input dest_tag_t dest);
    issue_t item;
    item.valid      = 1'b1;
    item.ir         = ir;
    item.pra        = pra;
    item.prb        = prb;
    item.opb_select = sel;
    item.dest       = dest;
    return item;
  endfunction

  // any select code, unused ones included
  function automatic issue_t random_issue();
    return make_issue(rand64(), rand64(), opb_sel_e'(2'($urandom_range(3, 0))),
                      $urandom, rand_tag());
  endfunction

  // next rising edge, both lanes default to no issue
  task automatic idle_cycle();
    @(posedge clock);
    for (int lane = 0; lane < LANES; lane++)
      issue[lane].valid <= 1'b0;
  endtask

  task automatic drive(input int lane, input issue_t item);
    issue[lane] <= item;                    // overrides the idle default
  endtask

  // run idle cycles until both scoreboards are empty, checked at negedge
  task automatic wait_drain();
    logic busy;
    idle_cycle();
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clock);
      busy = (exp_q[0].size() != 0) || (exp_q[1].size() != 0);
      if (busy)
        idle_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard, sees the same edge values as the DUT
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clock)
  begin : monitor
    exp_t e;
    int   lag;
    for (int lane = 0; lane < LANES; lane++)
    begin
      if (cdb[lane].complete)
      begin
        seen_count++;
        assert (exp_q[lane].size() != 0)
        else
        begin
          $display("lane %0d completed at %0t with nothing in flight", lane, $time);
          protocol_errors++;
        end
        if (exp_q[lane].size() != 0)
        begin
          e   = exp_q[lane].pop_front();    // in-order within a lane
          lag = cycle_count - int'(e.cycle);
          assert (lag == LATENCY)
          else
          begin
            $display("lane %0d completed %0d cycles after issue at %0t, wanted %0d",
                     lane, lag, $time, LATENCY);
            protocol_errors++;
          end
          assert (cdb[lane].result === e.result)
          else
          begin
            $display("Error %0t: cdb[%0d].result expected %h got %h",
                     $time, lane, e.result, cdb[lane].result);
            value_errors++;
          end
          assert (cdb[lane].dest === e.dest)
          else
          begin
            $display("Error %0t: cdb[%0d].dest expected %h got %h",
                     $time, lane, e.dest, cdb[lane].dest);
            value_errors++;
          end
        end
      end
    end
    for (int lane = 0; lane < LANES; lane++)
    begin
      if (reset)
        exp_q[lane].delete();               // in-flight work is discarded
      else if (issue[lane].valid)
      begin
        e.result = model_result(issue[lane]);
        e.dest   = issue[lane].dest;
        e.cycle  = cycle_count;
        exp_q[lane].push_back(e);
        issued_count++;
      end
    end
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("run stopped after %0d cycles without finishing", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  // reset held 3 cycles, then 8 quiet cycles
  task automatic test_reset();
    repeat (3) idle_cycle();
    reset <= 1'b0;
    repeat (8) idle_cycle();
    @(negedge clock);
    assert (seen_count == 0)
    else
    begin
      $display("complete went high during or right after reset");
      protocol_errors++;
    end
  endtask

  task automatic test_register_operands();
    word_t a;
    word_t b;
    for (int i = 0; i < REG_ISSUES / 2; i++)
    begin
      case (i)
        0:       begin a = '0;           b = rand64();    end
        1:       begin a = 64'd1;        b = 64'd1;       end
        2:       begin a = '1;           b = '1;          end
        3:       begin a = '1;           b = 64'd1;       end
        4:       begin a = 64'd1 << 63;  b = 64'd2;       end  // wraps to zero
        5:       begin a = rand64();     b = '0;          end
        default: begin a = rand64();     b = rand64();    end
      endcase
      idle_cycle();
      drive(0, make_issue(a, b, OPB_IS_REGB, $urandom, rand_tag()));
      drive(1, make_issue(b, a, OPB_IS_REGB, $urandom, rand_tag()));
    end
    wait_drain();
  endtask

  // same register A and literal on both lanes, register B differs
  task automatic test_immediate();
    word_t a;
    inst_t ir;
    for (int i = 0; i < IMM_ISSUES / 2; i++)
    begin
      a  = (i == 0) ? '1 : rand64();
      ir = (i == 1) ? 32'h001f_e000 : $urandom;   // all ones literal
      idle_cycle();
      drive(0, make_issue(a, rand64(), OPB_IS_ALU_IMM, ir, rand_tag()));
      drive(1, make_issue(a, rand64(), OPB_IS_ALU_IMM, ir, rand_tag()));
    end
    wait_drain();
  endtask

  task automatic test_streaming();
    for (int i = 0; i < STREAM_ISSUES / 2; i++)
    begin
      idle_cycle();
      drive(0, random_issue());
      drive(1, random_issue());
    end
    wait_drain();
  endtask

  // invalid slots still carry random payload
  task automatic test_bubbles();
    int     issued_start;
    int     seen_start;
    issue_t item;
    issued_start = issued_count;
    seen_start   = seen_count;
    for (int i = 0; i < BUBBLE_ISSUES; i++)
    begin
      idle_cycle();
      for (int lane = 0; lane < LANES; lane++)
      begin
        item       = random_issue();
        item.valid = $urandom_range(1, 0) != 0;
        drive(lane, item);
      end
    end
    wait_drain();
    assert (seen_count - seen_start == issued_count - issued_start)
    else
    begin
      $display("%0d completions for %0d valid issues in the bubble test",
               seen_count - seen_start, issued_count - issued_start);
      protocol_errors++;
    end
  endtask

  task automatic test_midflight_reset();
    int seen_start;
    seen_start = seen_count;
    for (int i = 0; i < 3; i++)
    begin
      idle_cycle();
      drive(0, random_issue());
      drive(1, random_issue());
    end
    idle_cycle();
    reset <= 1'b1;                          // oldest op is two edges from done
    repeat (3) idle_cycle();
    reset <= 1'b0;
    repeat (8) idle_cycle();
    @(negedge clock);
    assert (seen_count == seen_start)
    else
    begin
      $display("an instruction flushed by reset still completed");
      protocol_errors++;
    end
    idle_cycle();
    drive(0, random_issue());
    wait_drain();
    assert (seen_count == seen_start + 1)
    else
    begin
      $display("issue after the mid-flight reset did not complete once");
      protocol_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    void'($urandom(32'h3bad_c04d));
    clock = 1'b0;
    reset = 1'b1;
    for (int lane = 0; lane < LANES; lane++)
      issue[lane] = '0;
    test_reset();
    test_register_operands();
    test_immediate();
    test_streaming();
    test_bubbles();
    test_midflight_reset();
    $display("checks done, %0d value errors, %0d protocol errors, %0d results",
             value_errors, protocol_errors, seen_count);
    if (value_errors == 0 && protocol_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- src.f
src/mul_pkg.sv
src/mult_stage.sv
src/mult_pipe.sv
src/mul_operand_sel.sv
src/alu_mul.sv
tb/tb_alu_mul.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_alu_mul
FILELIST  = src.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
